// ==== eth_consts.svh ====
`ifndef ETH_CONSTS_SVH
`define ETH_CONSTS_SVH

////////////////////
// Frame framing bytes
////////////////////
`define ETH_PREAMBLE_BYTE 8'h55          // Repeated 7 times before SFD
`define ETH_SFD_BYTE      8'hD5          // Start frame delimiter
`define ETH_PAD_BYTE      8'h00          // Fill up to minimum length

// Frame sizes in bytes, header + payload + pad, FCS excluded
`define ETH_MIN_FRAME     60
`define ETH_MAX_FRAME     500
`define ETH_FIFO_DEPTH    512            // Power of two, >= max frame

`define ETH_CRC_SEED      32'hFFFF_FFFF  // Running CRC start value

// Inter-frame gap in clock cycles, 96 bit times at each link rate
`define ETH_IFG_1000      12
`define ETH_IFG_100       120
`define ETH_IFG_10        1200

`endif

// ==== eth_pkg.sv ====
package eth_pkg;

    ////////////////////
    // Frame descriptor
    ////////////////////
    typedef struct packed {
        logic [47:0] dst_mac;    // Sent first, MSB first
        logic [47:0] src_mac;
        logic [15:0] ethertype;  // Type or length field
    } eth_hdr_t;

    // One beat of a byte stream
    typedef struct packed {
        logic [7:0] data;
        logic       last;        // High on final byte of a frame
    } eth_byte_t;

    // FCS seen as a word by the CRC and as bytes by the MAC
    // Byte 0 is bits 7:0 and leaves the MAC first
    typedef union packed {
        logic [31:0]     word;
        logic [3:0][7:0] bytes;
    } fcs_word_u;

    // Link rate, picks the inter-frame gap length
    typedef enum logic [1:0] {
        SPEED_10   = 2'b00,
        SPEED_100  = 2'b01,
        SPEED_1000 = 2'b10
    } link_speed_e;

endpackage

// ==== eth_crc32.sv ====
`timescale 1ns/10ps
`include "eth_consts.svh"

module eth_crc32 (
    input  logic              clk,
    input  logic              reset_n,
    input  logic              init,     // Reload seed, start of frame
    input  logic              en,       // Fold one byte into the CRC
    input  logic [7:0]        data,
    output eth_pkg::fcs_word_u fcs
);

    localparam logic [31:0] POLY = 32'hEDB8_8320; // Reflected 802.3 polynomial

    logic [31:0] crc_q;   // Running remainder
    logic [31:0] crc_d;

    // One byte, LSB first, bitwise shift and conditional XOR
    function automatic logic [31:0] crc_step(input logic [31:0] c, input logic [7:0] d);
        logic [31:0] r;
        r = c;
        for (int i = 0; i < 8; i++) begin
            if (r[0] ^ d[i]) begin
                r = (r >> 1) ^ POLY;
            end else begin
                r = r >> 1;
            end
        end
        return r;
    endfunction

    assign crc_d = crc_step(crc_q, data);

    always_ff @(posedge clk) begin
        if (reset_n || init) begin
            crc_q <= `ETH_CRC_SEED;
        end else if (en) begin
            crc_q <= crc_d;
        end
    end

    assign fcs.word = ~crc_q;  // Final complement, ready as soon as last byte is folded in

endmodule

// ==== eth_hdr_insert.sv ====
`timescale 1ns/10ps

module eth_hdr_insert (
    input  logic                clk,
    input  logic                reset_n,
    input  eth_pkg::eth_hdr_t   hdr,
    input  logic                hdr_valid,
    output logic                hdr_ready,
    input  eth_pkg::eth_byte_t  pay,
    input  logic                pay_valid,
    output logic                pay_ready,
    output eth_pkg::eth_byte_t  fifo_in,
    output logic                fifo_in_valid,
    input  logic                fifo_in_ready
);

    typedef enum logic [1:0] {
        st_idle,   // Waiting for a descriptor
        st_hdr,    // Sending the 14 header bytes
        st_pay     // Payload passes straight through
    } state_t;

    state_t            state;
    eth_pkg::eth_hdr_t hdr_q;     // Held descriptor
    logic [3:0]        byte_idx;  // Index of the header byte being offered
    logic [7:0]        hdr_byte;

    // Byte 0 is the top byte of dst_mac and each field goes out MSB first
    assign hdr_byte = hdr_q[(13 - int'(byte_idx)) * 8 +: 8];

    ////////////////////
    // Output mux
    ////////////////////
    always_comb begin
        fifo_in       = '0;
        fifo_in_valid = 1'b0;
        pay_ready     = 1'b0;
        case (state)
            st_hdr: begin
                fifo_in.data  = hdr_byte;
                fifo_in.last  = 1'b0;      // Header never ends a frame
                fifo_in_valid = 1'b1;
            end
            st_pay: begin
                fifo_in       = pay;       // Zero-latency pass-through
                fifo_in_valid = pay_valid;
                pay_ready     = fifo_in_ready;
            end
            default: ;
        endcase
    end

    // Descriptor capture on accept
    always_ff @(posedge clk) begin
        if (hdr_valid && hdr_ready) begin
            hdr_q <= hdr;
        end
    end

    ////////////////////
    // Control FSM
    ////////////////////
    always_ff @(posedge clk) begin
        if (reset_n) begin
            state     <= st_idle;
            hdr_ready <= 1'b0;
            byte_idx  <= 4'd0;
        end else begin
            case (state)
                st_idle: begin
                    hdr_ready <= 1'b1;
                    if (hdr_valid && hdr_ready) begin
                        state     <= st_hdr;
                        hdr_ready <= 1'b0;
                        byte_idx  <= 4'd0;
                    end
                end
                st_hdr: if (fifo_in_ready) begin       // One header byte per accepted beat
                    byte_idx <= byte_idx + 4'd1;
                    if (byte_idx == 4'd13) state <= st_pay;
                end
                st_pay: if (pay_valid && fifo_in_ready && pay.last) begin
                    state     <= st_idle;
                    hdr_ready <= 1'b1;                 // Next descriptor right away
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Host payload must wait until all 14 header bytes are out
    a_no_pay_in_hdr: assert property (@(posedge clk) disable iff (reset_n)
        pay_ready |-> byte_idx == 4'd14);

endmodule

// ==== eth_tx_fifo.sv ====
`timescale 1ns/10ps
`include "eth_consts.svh"

module eth_tx_fifo #(
    parameter int DEPTH = `ETH_FIFO_DEPTH  // Power of two, holds one max frame
) (
    input  logic               clk,
    input  logic               reset_n,
    input  eth_pkg::eth_byte_t fifo_in,
    input  logic               fifo_in_valid,
    output logic               fifo_in_ready,
    output eth_pkg::eth_byte_t mac_in,
    output logic               mac_in_valid,
    input  logic               mac_in_ready
);

    localparam int AW = $clog2(DEPTH);

    eth_pkg::eth_byte_t mem [DEPTH];  // Byte storage, no reset
    logic [AW-1:0]      wr_ptr;
    logic [AW-1:0]      rd_ptr;
    logic [AW:0]        fill;         // Bytes stored
    logic [AW:0]        fill_next;
    logic [AW:0]        frames;       // Complete frames stored
    logic               wr_en;
    logic               rd_en;

    assign wr_en = fifo_in_valid && fifo_in_ready;
    assign rd_en = mac_in_valid && mac_in_ready;

    assign fill_next = fill + (AW+1)'(wr_en) - (AW+1)'(rd_en);

    // Packet mode, nothing offered until a whole frame is in
    assign mac_in_valid = (frames != '0);
    assign mac_in       = mem[rd_ptr];    // Readable the cycle after write

    always_ff @(posedge clk) begin
        if (wr_en) mem[wr_ptr] <= fifo_in;
    end

    ////////////////////
    // Pointers and counts
    ////////////////////
    always_ff @(posedge clk) begin
        if (reset_n) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            fill          <= '0;
            frames        <= '0;
            fifo_in_ready <= 1'b0;
        end else begin
            if (wr_en) wr_ptr <= wr_ptr + AW'(1);  // Wraps at DEPTH
            if (rd_en) rd_ptr <= rd_ptr + AW'(1);
            fill          <= fill_next;
            fifo_in_ready <= (fill_next != (AW+1)'(DEPTH));  // Registered not-full
            case ({wr_en && fifo_in.last, rd_en && mac_in.last})
                2'b10:   frames <= frames + (AW+1)'(1);      // Frame completed
                2'b01:   frames <= frames - (AW+1)'(1);      // Frame drained
                default: ;
            endcase
        end
    end

    initial begin
        assert (DEPTH >= `ETH_MAX_FRAME && (DEPTH & (DEPTH - 1)) == 0)
            else $error("eth_tx_fifo DEPTH %0d must be a power of two >= max frame", DEPTH);
    end

    // Registered ready must never let a write land on a full buffer
    a_no_write_full: assert property (@(posedge clk) disable iff (reset_n)
        wr_en |-> fill != (AW+1)'(DEPTH));

    // MAC only pulls bytes while a complete frame is held
    a_no_read_empty: assert property (@(posedge clk) disable iff (reset_n)
        mac_in_ready |-> frames != '0);

endmodule

// ==== eth_tx_mac.sv ====
`timescale 1ns/10ps
`include "eth_consts.svh"

module eth_tx_mac (
    input  logic                 clk,
    input  logic                 reset_n,
    input  eth_pkg::eth_byte_t   mac_in,
    input  logic                 mac_in_valid,
    output logic                 mac_in_ready,
    input  logic                 phy_ready,    // Low freezes the whole MAC
    output logic [7:0]           tx_data,
    output logic                 tx_dv,
    input  eth_pkg::link_speed_e link_speed
);

    localparam logic [5:0] MIN_LEN = 6'(`ETH_MIN_FRAME);

    typedef enum logic [2:0] {
        st_idle,   // Waiting for a stored frame
        st_pre,    // 7 preamble bytes then SFD
        st_pay,    // Header and payload from FIFO
        st_pad,    // Zero fill up to 60 bytes
        st_fcs,    // 4 CRC bytes, low byte first
        st_gap     // Inter-frame gap
    } state_t;

    state_t             state;
    logic [2:0]         pre_cnt;    // Preamble byte index, 7 is SFD
    logic [5:0]         frame_len;  // Bytes sent after SFD, saturates at 60
    logic [5:0]         len_inc;
    logic [1:0]         fcs_idx;    // FCS byte being sent
    logic [10:0]        gap_cnt;
    logic [10:0]        gap_limit;  // Latched in idle from link_speed
    logic               crc_init;
    logic               crc_en;
    logic [7:0]         crc_data;
    eth_pkg::fcs_word_u fcs;

    // Gap length per link rate, clock stays at 125 MHz
    function automatic logic [10:0] ifg_cycles(input eth_pkg::link_speed_e spd);
        case (spd)
            eth_pkg::SPEED_10:  return 11'(`ETH_IFG_10);
            eth_pkg::SPEED_100: return 11'(`ETH_IFG_100);
            default:            return 11'(`ETH_IFG_1000);
        endcase
    endfunction

    assign len_inc = (frame_len == MIN_LEN) ? MIN_LEN : frame_len + 6'd1;

    // One FIFO byte per sending cycle
    assign mac_in_ready = (state == st_pay) && phy_ready;

    ////////////////////
    // CRC feed
    ////////////////////
    assign crc_init = phy_ready && (state == st_idle) && mac_in_valid; // Seed on leaving idle
    assign crc_en   = (mac_in_valid && mac_in_ready) || (phy_ready && state == st_pad);
    assign crc_data = (state == st_pay) ? mac_in.data : `ETH_PAD_BYTE;

    eth_crc32 u_crc (
        .clk     (clk),
        .reset_n (reset_n),
        .init    (crc_init),
        .en      (crc_en),
        .data    (crc_data),
        .fcs     (fcs)
    );

    ////////////////////
    // Transmit FSM
    ////////////////////
    always_ff @(posedge clk) begin
        if (reset_n) begin
            state     <= st_idle;
            tx_data   <= 8'h00;
            tx_dv     <= 1'b0;
            pre_cnt   <= 3'd0;
            frame_len <= 6'd0;
            fcs_idx   <= 2'd0;
            gap_cnt   <= 11'd0;
            gap_limit <= 11'(`ETH_IFG_1000);
        end else if (phy_ready) begin                  // Otherwise hold everything
            case (state)
                st_idle: begin
                    tx_dv     <= 1'b0;
                    pre_cnt   <= 3'd0;
                    frame_len <= 6'd0;
                    fcs_idx   <= 2'd0;
                    gap_limit <= ifg_cycles(link_speed);
                    if (mac_in_valid) state <= st_pre;
                end
                st_pre: begin
                    tx_dv   <= 1'b1;
                    tx_data <= (pre_cnt == 3'd7) ? `ETH_SFD_BYTE : `ETH_PREAMBLE_BYTE;
                    pre_cnt <= pre_cnt + 3'd1;
                    if (pre_cnt == 3'd7) state <= st_pay;
                end
                st_pay: begin
                    tx_dv     <= 1'b1;
                    tx_data   <= mac_in.data;
                    frame_len <= len_inc;
                    if (mac_in.last) begin
                        // Short frame goes to padding, else straight to FCS
                        state <= (len_inc == MIN_LEN) ? st_fcs : st_pad;
                    end
                end
                st_pad: begin
                    tx_dv     <= 1'b1;
                    tx_data   <= `ETH_PAD_BYTE;
                    frame_len <= len_inc;
                    if (len_inc == MIN_LEN) state <= st_fcs;  // 60th byte sent now
                end
                st_fcs: begin
                    tx_dv   <= 1'b1;
                    tx_data <= fcs.bytes[fcs_idx];   // CRC reg already holds the last byte
                    fcs_idx <= fcs_idx + 2'd1;
                    if (fcs_idx == 2'd3) begin
                        state   <= st_gap;
                        gap_cnt <= 11'd0;
                    end
                end
                st_gap: begin
                    tx_dv   <= 1'b0;
                    gap_cnt <= gap_cnt + 11'd1;
                    if (gap_cnt == gap_limit - 11'd1) state <= st_idle;
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Packet-mode FIFO must keep bytes coming until the frame ends
    a_no_underrun: assert property (@(posedge clk) disable iff (reset_n)
        (state == st_pay && phy_ready) |-> mac_in_valid);

endmodule

// ==== eth_tx_top.sv ====
`timescale 1ns/10ps

module eth_tx_top (
    input  logic                 clk,
    input  logic                 reset_n,
    input  eth_pkg::eth_hdr_t    hdr,
    input  logic                 hdr_valid,
    output logic                 hdr_ready,
    input  eth_pkg::eth_byte_t   pay,
    input  logic                 pay_valid,
    output logic                 pay_ready,
    input  logic                 phy_ready,
    output logic [7:0]           tx_data,
    output logic                 tx_dv,
    input  eth_pkg::link_speed_e link_speed
);

    // Producer to buffer
    eth_pkg::eth_byte_t fifo_in;
    logic               fifo_in_valid;
    logic               fifo_in_ready;

    // Buffer to consumer
    eth_pkg::eth_byte_t mac_in;
    logic               mac_in_valid;
    logic               mac_in_ready;

    eth_hdr_insert u_hdr (
        .clk           (clk),
        .reset_n       (reset_n),
        .hdr           (hdr),
        .hdr_valid     (hdr_valid),
        .hdr_ready     (hdr_ready),
        .pay           (pay),
        .pay_valid     (pay_valid),
        .pay_ready     (pay_ready),
        .fifo_in       (fifo_in),
        .fifo_in_valid (fifo_in_valid),
        .fifo_in_ready (fifo_in_ready)
    );

    eth_tx_fifo u_fifo (
        .clk           (clk),
        .reset_n       (reset_n),
        .fifo_in       (fifo_in),
        .fifo_in_valid (fifo_in_valid),
        .fifo_in_ready (fifo_in_ready),
        .mac_in        (mac_in),
        .mac_in_valid  (mac_in_valid),
        .mac_in_ready  (mac_in_ready)
    );

    eth_tx_mac u_mac (
        .clk          (clk),
        .reset_n      (reset_n),
        .mac_in       (mac_in),
        .mac_in_valid (mac_in_valid),
        .mac_in_ready (mac_in_ready),
        .phy_ready    (phy_ready),
        .tx_data      (tx_data),
        .tx_dv        (tx_dv),
        .link_speed   (link_speed)
    );

endmodule

// ==== eth_tx_tb.sv ====
`timescale 1ns/10ps
`include "eth_consts.svh"

module eth_tx_tb;

    localparam int NF  = 8;   // Frames in the data file
    localparam int REC = 7;   // Words per record

    logic                 clk;
    logic                 reset_n;
    eth_pkg::eth_hdr_t    hdr;
    logic                 hdr_valid;
    logic                 hdr_ready;
    eth_pkg::eth_byte_t   pay;
    logic                 pay_valid;
    logic                 pay_ready;
    logic                 phy_ready;
    logic [7:0]           tx_data;
    logic                 tx_dv;
    eth_pkg::link_speed_e link_speed;

    logic [63:0] td [0:NF*REC-1];    // mode speed dst src type len seed
    logic [7:0]  exp_q [$];          // Expected burst of the frame under check
    logic [7:0]  got_q [$];          // Bytes taken from tx_data
    logic [19:0] host_lfsr = 20'd90856;
    logic [19:0] phy_lfsr  = 20'd90856;
    int          errors    = 0;
    int          cur       = 0;      // Frame the monitor is waiting on
    int          cycles    = 0;
    int          limit     = 100000;
    int          burst_cyc = 0;
    int          gap       = 0;
    logic        in_burst  = 1'b0;

    eth_tx_top uut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;   // 4 ns period
    end

    ////////////////////
    // Helpers
    ////////////////////
    // Fibonacci LFSR with taps for x^20 + x^17 + 1
    function automatic logic [19:0] lfsr_step(input logic [19:0] s);
        return {s[18:0], s[19] ^ s[16]};
    endfunction

    function automatic logic [7:0] pay_byte(input int k, input int i);
        return 8'(td[k*REC+6] + i * 7 + (i >> 8));   // Whole index feeds the pattern
    endfunction

    function automatic int ifg_of(input logic [63:0] spd);
        case (spd)
            64'd0:   return `ETH_IFG_10;
            64'd1:   return `ETH_IFG_100;
            default: return `ETH_IFG_1000;
        endcase
    endfunction

    // Reflected CRC-32 taking the LSB of each byte first
    function automatic logic [31:0] crc_byte(input logic [31:0] c, input logic [7:0] d);
        logic fb;
        for (int b = 0; b < 8; b++) begin
            fb = c[0] ^ d[b];
            c  = (c >> 1) ^ ({32{fb}} & 32'hEDB8_8320);
        end
        return c;
    endfunction

    task automatic build_expected(input int k);
        logic [111:0] h;
        logic [31:0]  crc;
        h = {td[k*REC+2][47:0], td[k*REC+3][47:0], td[k*REC+4][15:0]};
        exp_q.delete();
        repeat (7) exp_q.push_back(`ETH_PREAMBLE_BYTE);
        exp_q.push_back(`ETH_SFD_BYTE);
        for (int i = 0; i < 14; i++) exp_q.push_back(h[111 - 8*i -: 8]);   // MSB first
        for (int i = 0; i < int'(td[k*REC+5]); i++) exp_q.push_back(pay_byte(k, i));
        while (exp_q.size() < 8 + `ETH_MIN_FRAME) exp_q.push_back(`ETH_PAD_BYTE);
        crc = `ETH_CRC_SEED;
        for (int i = 8; i < exp_q.size(); i++) crc = crc_byte(crc, exp_q[i]);
        crc = ~crc;
        for (int i = 0; i < 4; i++) exp_q.push_back(crc[8*i +: 8]);   // Low byte first
    endtask

    task automatic check_frame(input int k);
        int bad;
        bad = 0;
        build_expected(k);
        if (got_q.size() != exp_q.size()) begin
            $display("frame %0d sent %0d bytes but %0d were expected", k, got_q.size(),
                     exp_q.size());
            bad++;
        end
        for (int i = 0; i < got_q.size() && i < exp_q.size(); i++) begin
            if (got_q[i] != exp_q[i]) begin
                $display("FAIL frame %0d tx_data byte %0d: got %h expected %h", k, i,
                         got_q[i], exp_q[i]);
                bad++;
            end
        end
        if (td[k*REC] == 0 && burst_cyc != exp_q.size()) begin   // Steady PHY only
            $display("frame %0d kept tx_dv high %0d cycles instead of %0d", k, burst_cyc,
                     exp_q.size());
            bad++;
        end
        errors += bad;
        $display("frame %0d: %0d bytes, %0d errors", k, got_q.size(), bad);
    endtask

    // Host side of one frame with acceptance sampled on the falling edge before the taking edge
    task automatic send_frame(input int k);
        logic acc;
        hdr       = {td[k*REC+2][47:0], td[k*REC+3][47:0], td[k*REC+4][15:0]};
        hdr_valid = 1'b1;
        do begin
            @(negedge clk) acc = hdr_ready;
            @(posedge clk) #1;
        end while (!acc);
        hdr_valid = 1'b0;
        for (int i = 0; i < int'(td[k*REC+5]); i++) begin
            while (td[k*REC] != 0) begin   // Random idle beats before valid rises
                host_lfsr = lfsr_step(host_lfsr);
                if (host_lfsr[0]) break;
                @(posedge clk) #1;
            end
            pay.data  = pay_byte(k, i);
            pay.last  = (i == int'(td[k*REC+5]) - 1);
            pay_valid = 1'b1;
            do begin
                @(negedge clk) acc = pay_ready;
                @(posedge clk) #1;
            end while (!acc);
            pay_valid = 1'b0;
        end
    endtask

    ////////////////////
    // PHY side and watchdog
    ////////////////////
    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            $display("run stopped after %0d cycles, frame %0d never finished", cycles, cur);
            $display("TB FAILED");
            $finish;
        end else begin
            #1;
            link_speed = eth_pkg::link_speed_e'(td[(cur < NF ? cur : NF-1)*REC+1][1:0]);
            phy_ready  = 1'b1;
            if (cur < NF && td[cur*REC] != 0) begin   // Drop ready on about one cycle in four
                phy_lfsr  = lfsr_step(phy_lfsr);
                phy_ready = phy_lfsr[0];
                phy_lfsr  = lfsr_step(phy_lfsr);
                phy_ready = phy_ready | phy_lfsr[0];
            end
        end
    end

    // Monitor samples mid-cycle where outputs are settled
    always @(negedge clk) begin
        if (!reset_n && cur < NF) begin
            if (tx_dv) begin
                if (!in_burst) begin
                    if (cur > 0 && gap < ifg_of(td[(cur-1)*REC+1])) begin
                        $display("gap before frame %0d was only %0d cycles", cur, gap);
                        errors++;
                    end
                    in_burst  = 1'b1;
                    burst_cyc = 0;
                    got_q.delete();
                end
                burst_cyc++;
                if (phy_ready) got_q.push_back(tx_data);   // Byte taken on the coming edge
            end else if (in_burst) begin
                check_frame(cur);
                in_burst = 1'b0;
                gap      = phy_ready ? 1 : 0;
                cur++;
            end else if (phy_ready) begin
                gap++;
            end
        end
    end

    ////////////////////
    // Main sequence
    ////////////////////
    initial begin
        int sum;
        reset_n    = 1'b1;   // Reset is active high
        hdr        = '0;
        hdr_valid  = 1'b0;
        pay        = '0;
        pay_valid  = 1'b0;
        phy_ready  = 1'b1;
        link_speed = eth_pkg::SPEED_1000;
        $readmemh("eth_testdata.txt", td);
        sum = 0;
        for (int k = 0; k < NF; k++) begin
            sum += 12 + (int'(td[k*REC+5]) + 14 > 60 ? int'(td[k*REC+5]) + 14 : 60);
            sum += ifg_of(td[k*REC+1]) + 8;
        end
        limit = sum * 4 + 100;
        repeat (4) @(posedge clk);
        #1 reset_n = 1'b0;
        for (int k = 0; k < NF; k++) send_frame(k);
        wait (cur == NF);
        repeat (5) @(posedge clk);
        $display("%0d frames checked, %0d errors", cur, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== eth_testdata.txt ====
// mode(0 steady, 1 random gaps) speed(0=10,1=100,2=1000) dst_mac src_mac ethertype
// payload_len payload_seed, payload byte i = seed + 7*i + (i >> 8)
0 2 FFFFFFFFFFFF 02AABBCC0001 0800 0001 11
0 2 001B21334455 02AABBCC0001 0806 002E 22
0 1 0180C2000001 02AABBCC0002 88B5 01E6 33
0 0 00A0C9ABCDEF 02AABBCC0003 0800 002D 44
1 2 112233445566 02AABBCC0004 86DD 0040 55
1 2 FFFFFFFFFFFF 02AABBCC0005 0806 0005 66
1 2 3C5A7E9B0D21 02AABBCC0006 0800 0100 77
1 2 0180C2000002 02AABBCC0007 88CC 01E6 88

// ==== sources.f ====
+incdir+.
eth_pkg.sv
eth_crc32.sv
eth_hdr_insert.sv
eth_tx_fifo.sv
eth_tx_mac.sv
eth_tx_top.sv
eth_tx_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= eth_tx_tb
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

SRCS := $(shell grep -v '^+' sources.f)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: run clean

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "TB PASSED" $(LOG)

$(BIN): $(SRCS) eth_consts.svh sources.f
	$(VERILATOR) $(VFLAGS) -f sources.f --top-module $(TOP) -Mdir $(OBJ_DIR)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
